/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// data path and byte address width
	localparam int XLEN = 32;
	// rob tag width
	localparam int ROB_TAG_W = 6;

	// store queue depth, power of two so the pointers wrap by themselves
	localparam int STQ_SIZE = 8;
	localparam int STQ_IDX_W = 3;

	// data memory depth in words
	localparam int MEM_WORDS = 256;
	// word index taken from address bits MEM_IDX_W+1 down to 2
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	typedef logic [XLEN-1:0] data_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [STQ_IDX_W-1:0] stq_idx_t;
	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

	// drain fsm
	// idle waits on the head entry, write holds the request,
	// retire reports success for one cycle
	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		RETIRE
	} drain_state_t;

endpackage

`default_nettype wire

/* design/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  logic clk,
	input  logic reset,

	// allocation from dispatch
	input  logic alloc_valid,
	output logic alloc_ready,
	input  lsu_pkg::rob_tag_t alloc_tag,
	input  lsu_pkg::data_t alloc_data,
	input  logic alloc_data_valid,

	// agu address pulse
	input  logic agu_valid,
	input  lsu_pkg::rob_tag_t agu_tag,
	input  lsu_pkg::addr_t agu_addr,

	// cdb broadcast pulse
	input  logic cdb_valid,
	input  lsu_pkg::rob_tag_t cdb_tag,
	input  lsu_pkg::data_t cdb_data,

	// rob commit pulse
	input  logic commit_valid,
	input  lsu_pkg::rob_tag_t commit_tag,

	// success pulse from the drain fsm
	input  logic store_succeeded,
	input  lsu_pkg::rob_tag_t succeeded_tag,

	// entry contents
	output logic [lsu_pkg::STQ_SIZE-1:0] stq_valid,
	output logic [lsu_pkg::STQ_SIZE-1:0] stq_addr_valid,
	output logic [lsu_pkg::STQ_SIZE-1:0] stq_data_valid,
	output logic [lsu_pkg::STQ_SIZE-1:0] stq_committed,
	output logic [lsu_pkg::STQ_SIZE-1:0] stq_succeeded,
	output lsu_pkg::addr_t [lsu_pkg::STQ_SIZE-1:0] stq_addr,
	output lsu_pkg::data_t [lsu_pkg::STQ_SIZE-1:0] stq_data,
	output lsu_pkg::rob_tag_t [lsu_pkg::STQ_SIZE-1:0] stq_tag,

	// circular buffer pointers
	output lsu_pkg::stq_idx_t head,
	output lsu_pkg::stq_idx_t tail,
	output logic stq_empty
);
	import lsu_pkg::*;

	logic alloc_fire;
	logic alloc_take_cdb;

	// tail points at the next free slot, so a valid tail slot means full
	assign alloc_ready = !stq_valid[tail];
	assign alloc_fire = alloc_valid && alloc_ready;
	assign stq_empty = !(|stq_valid);

	// data for the store being allocated may show up on the cdb in the same cycle
	assign alloc_take_cdb = cdb_valid && (cdb_tag == alloc_tag) && !alloc_data_valid;

	// status bits
	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			stq_valid <= '0;
			stq_addr_valid <= '0;
			stq_data_valid <= '0;
			stq_committed <= '0;
			stq_succeeded <= '0;
		end else begin
			if (alloc_fire) begin
				stq_valid[tail] <= 1'b1;
				stq_addr_valid[tail] <= 1'b0;
				stq_data_valid[tail] <= alloc_data_valid || alloc_take_cdb;
				stq_committed[tail] <= 1'b0;
				stq_succeeded[tail] <= 1'b0;
				tail <= tail + stq_idx_t'(1);
			end

			// every tag bus updates the live entry holding that tag
			for (int i = 0; i < STQ_SIZE; i++) begin
				if (stq_valid[i] && agu_valid && agu_tag == stq_tag[i]) begin
					stq_addr_valid[i] <= 1'b1;
				end
				if (stq_valid[i] && cdb_valid && cdb_tag == stq_tag[i]) begin
					stq_data_valid[i] <= 1'b1;
				end
				if (stq_valid[i] && commit_valid && commit_tag == stq_tag[i]) begin
					stq_committed[i] <= 1'b1;
				end
				if (stq_valid[i] && store_succeeded && succeeded_tag == stq_tag[i]) begin
					stq_succeeded[i] <= 1'b1;
				end
			end

			// head written to memory, free it and move on
			if (stq_valid[head] && stq_succeeded[head]) begin
				stq_valid[head] <= 1'b0;
				stq_addr_valid[head] <= 1'b0;
				stq_data_valid[head] <= 1'b0;
				stq_committed[head] <= 1'b0;
				stq_succeeded[head] <= 1'b0;
				head <= head + stq_idx_t'(1);
			end
		end
	end

	// entry payload, qualified by the status bits above
	always_ff @(posedge clk) begin
		if (alloc_fire) begin
			stq_tag[tail] <= alloc_tag;
			stq_data[tail] <= alloc_take_cdb ? cdb_data : alloc_data;
		end
		for (int i = 0; i < STQ_SIZE; i++) begin
			if (stq_valid[i] && agu_valid && agu_tag == stq_tag[i]) begin
				stq_addr[i] <= agu_addr;
			end
			if (stq_valid[i] && cdb_valid && cdb_tag == stq_tag[i]) begin
				stq_data[i] <= cdb_data;
			end
		end
	end

endmodule

`default_nettype wire

/* design/store_drain_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module store_drain_ctrl (
	input  logic clk,
	input  logic reset,

	// queue view, only the head entry is ever used
	input  lsu_pkg::stq_idx_t head,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_valid,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_committed,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_addr_valid,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_data_valid,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_succeeded,
	input  lsu_pkg::addr_t [lsu_pkg::STQ_SIZE-1:0] stq_addr,
	input  lsu_pkg::data_t [lsu_pkg::STQ_SIZE-1:0] stq_data,
	input  lsu_pkg::rob_tag_t [lsu_pkg::STQ_SIZE-1:0] stq_tag,

	// memory write port
	output logic wr_valid,
	input  logic wr_ready,
	output lsu_pkg::addr_t wr_addr,
	output lsu_pkg::data_t wr_data,

	// success report back to the queue
	output logic store_succeeded,
	output lsu_pkg::rob_tag_t succeeded_tag
);
	import lsu_pkg::*;

	drain_state_t state;
	drain_state_t state_next;
	logic head_ready;

	// head is committed and complete, and has not been written yet
	// the succeeded check keeps a finished head from draining twice
	assign head_ready = stq_valid[head] && stq_committed[head] && stq_addr_valid[head] &&
		stq_data_valid[head] && !stq_succeeded[head];

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (head_ready) begin
					state_next = WRITE;
				end
			end
			// hold the request while memory serves loads
			WRITE: begin
				if (wr_ready) begin
					state_next = RETIRE;
				end
			end
			RETIRE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// capture the head entry on the way out of idle
	always_ff @(posedge clk) begin
		if (state == IDLE && head_ready) begin
			wr_addr <= stq_addr[head];
			wr_data <= stq_data[head];
			succeeded_tag <= stq_tag[head];
		end
	end

	assign wr_valid = (state == WRITE);
	// one cycle pulse, tag is the latched one
	assign store_succeeded = (state == RETIRE);

endmodule

`default_nettype wire

/* design/store_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module store_forward (
	input  lsu_pkg::stq_idx_t head,
	input  lsu_pkg::stq_idx_t tail,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_valid,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_addr_valid,
	input  logic [lsu_pkg::STQ_SIZE-1:0] stq_data_valid,
	input  lsu_pkg::addr_t [lsu_pkg::STQ_SIZE-1:0] stq_addr,
	input  lsu_pkg::data_t [lsu_pkg::STQ_SIZE-1:0] stq_data,

	// address of the load being presented
	input  lsu_pkg::addr_t load_addr,

	output logic fwd_hit,
	output lsu_pkg::data_t fwd_data,
	output logic fwd_stall
);
	import lsu_pkg::*;

	stq_idx_t idx;
	stq_idx_t match_idx;
	logic match_found;
	logic past_tail;

	// walk oldest to youngest starting at head
	// a later match overwrites an earlier one, so the youngest wins
	always_comb begin
		match_idx = head;
		match_found = 1'b0;
		past_tail = 1'b0;
		idx = head;
		for (int i = 0; i < STQ_SIZE; i++) begin
			idx = head + stq_idx_t'(i);
			// reaching tail again ends the live region
			// when full, head equals tail and the first slot still counts
			if (i != 0 && idx == tail) begin
				past_tail = 1'b1;
			end
			// stores with unknown address are skipped
			if (!past_tail && stq_valid[idx] && stq_addr_valid[idx] &&
				stq_addr[idx][XLEN-1:2] == load_addr[XLEN-1:2]) begin
				match_found = 1'b1;
				match_idx = idx;
			end
		end
	end

	// youngest match with data forwards, without data it stalls the load
	assign fwd_hit = match_found && stq_data_valid[match_idx];
	assign fwd_stall = match_found && !stq_data_valid[match_idx];
	assign fwd_data = stq_data[match_idx];

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic clk,
	input  logic reset,

	// load request and response
	input  logic load_valid,
	output logic load_ready,
	input  lsu_pkg::addr_t load_addr,
	output logic load_resp_valid,
	output lsu_pkg::data_t load_data,
	output logic load_forwarded,

	// forwarding result for the current load address
	input  logic fwd_hit,
	input  lsu_pkg::data_t fwd_data,
	input  logic fwd_stall,

	// drain write port
	input  logic wr_valid,
	output logic wr_ready,
	input  lsu_pkg::addr_t wr_addr,
	input  lsu_pkg::data_t wr_data
);
	import lsu_pkg::*;

	data_t mem [MEM_WORDS];
	mem_idx_t clr_idx;
	logic clearing;
	logic load_fire;

	// nothing accepted until the array is zeroed
	assign load_ready = !clearing && !fwd_stall;
	assign load_fire = load_valid && load_ready;
	// single port, a load takes the cycle and the write waits
	assign wr_ready = !clearing && !load_fire;

	// sweep one word per cycle after reset
	always_ff @(posedge clk) begin
		if (!reset) begin
			clearing <= 1'b1;
			clr_idx <= '0;
		end else if (clearing) begin
			clr_idx <= clr_idx + mem_idx_t'(1);
			if (clr_idx == mem_idx_t'(MEM_WORDS - 1)) begin
				clearing <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clearing) begin
			mem[clr_idx] <= '0;
		end else if (wr_valid && wr_ready) begin
			mem[wr_addr[MEM_IDX_W+1:2]] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			load_resp_valid <= 1'b0;
		end else begin
			load_resp_valid <= load_fire;
		end
	end

	// response word chosen at accept time
	// queued store data beats the array
	always_ff @(posedge clk) begin
		if (load_fire) begin
			load_forwarded <= fwd_hit;
			load_data <= fwd_hit ? fwd_data : mem[load_addr[MEM_IDX_W+1:2]];
		end
	end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  logic clk,
	input  logic reset,

	// allocation
	input  logic alloc_valid,
	output logic alloc_ready,
	input  lsu_pkg::rob_tag_t alloc_tag,
	input  lsu_pkg::data_t alloc_data,
	input  logic alloc_data_valid,

	// tag buses
	input  logic agu_valid,
	input  lsu_pkg::rob_tag_t agu_tag,
	input  lsu_pkg::addr_t agu_addr,
	input  logic cdb_valid,
	input  lsu_pkg::rob_tag_t cdb_tag,
	input  lsu_pkg::data_t cdb_data,
	input  logic commit_valid,
	input  lsu_pkg::rob_tag_t commit_tag,

	// loads
	input  logic load_valid,
	output logic load_ready,
	input  lsu_pkg::addr_t load_addr,
	output logic load_resp_valid,
	output lsu_pkg::data_t load_data,
	output logic load_forwarded,

	output logic stq_empty
);
	import lsu_pkg::*;

	// queue contents
	logic [STQ_SIZE-1:0] stq_valid;
	logic [STQ_SIZE-1:0] stq_addr_valid;
	logic [STQ_SIZE-1:0] stq_data_valid;
	logic [STQ_SIZE-1:0] stq_committed;
	logic [STQ_SIZE-1:0] stq_succeeded;
	addr_t [STQ_SIZE-1:0] stq_addr;
	data_t [STQ_SIZE-1:0] stq_data;
	rob_tag_t [STQ_SIZE-1:0] stq_tag;
	stq_idx_t head;
	stq_idx_t tail;

	// drain path
	logic wr_valid;
	logic wr_ready;
	addr_t wr_addr;
	data_t wr_data;
	logic store_succeeded;
	rob_tag_t succeeded_tag;

	// forwarding result
	logic fwd_hit;
	data_t fwd_data;
	logic fwd_stall;

	store_queue u_queue (
		.clk(clk),
		.reset(reset),
		.alloc_valid(alloc_valid),
		.alloc_ready(alloc_ready),
		.alloc_tag(alloc_tag),
		.alloc_data(alloc_data),
		.alloc_data_valid(alloc_data_valid),
		.agu_valid(agu_valid),
		.agu_tag(agu_tag),
		.agu_addr(agu_addr),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.commit_valid(commit_valid),
		.commit_tag(commit_tag),
		.store_succeeded(store_succeeded),
		.succeeded_tag(succeeded_tag),
		.stq_valid(stq_valid),
		.stq_addr_valid(stq_addr_valid),
		.stq_data_valid(stq_data_valid),
		.stq_committed(stq_committed),
		.stq_succeeded(stq_succeeded),
		.stq_addr(stq_addr),
		.stq_data(stq_data),
		.stq_tag(stq_tag),
		.head(head),
		.tail(tail),
		.stq_empty(stq_empty)
	);

	store_drain_ctrl u_drain (
		.clk(clk),
		.reset(reset),
		.head(head),
		.stq_valid(stq_valid),
		.stq_committed(stq_committed),
		.stq_addr_valid(stq_addr_valid),
		.stq_data_valid(stq_data_valid),
		.stq_succeeded(stq_succeeded),
		.stq_addr(stq_addr),
		.stq_data(stq_data),
		.stq_tag(stq_tag),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.store_succeeded(store_succeeded),
		.succeeded_tag(succeeded_tag)
	);

	// searched against the load address presented this cycle
	store_forward u_forward (
		.head(head),
		.tail(tail),
		.stq_valid(stq_valid),
		.stq_addr_valid(stq_addr_valid),
		.stq_data_valid(stq_data_valid),
		.stq_addr(stq_addr),
		.stq_data(stq_data),
		.load_addr(load_addr),
		.fwd_hit(fwd_hit),
		.fwd_data(fwd_data),
		.fwd_stall(fwd_stall)
	);

	data_mem u_mem (
		.clk(clk),
		.reset(reset),
		.load_valid(load_valid),
		.load_ready(load_ready),
		.load_addr(load_addr),
		.load_resp_valid(load_resp_valid),
		.load_data(load_data),
		.load_forwarded(load_forwarded),
		.fwd_hit(fwd_hit),
		.fwd_data(fwd_data),
		.fwd_stall(fwd_stall),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

endmodule

`default_nettype wire

/* verif/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
	import lsu_pkg::*;

	localparam int RAND_STEPS = 400;
	localparam int MAX_ST = 512;
	// watchdog budget per step
	localparam int STEP_CYCLES = 200;
	localparam logic [31:0] LFSR_SEED = 32'h8d91_7f76;
	// galois feedback for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// load outcome classes of the model
	localparam int LK_MEM = 0;
	localparam int LK_FWD = 1;
	localparam int LK_ANY = 2;
	localparam int LK_STALL = 3;

	typedef enum logic [2:0] {
		OP_ALLOC,
		OP_AGU,
		OP_CDB,
		OP_COMMIT,
		OP_LOAD,
		OP_STALL,
		OP_EMPTY,
		OP_READY
	} op_t;

	// exp_flag is load_forwarded for loads, alloc_ready for OP_READY
	typedef struct packed {
		op_t op;
		rob_tag_t tag;
		addr_t addr;
		data_t data;
		logic dv;
		data_t exp_data;
		logic exp_flag;
	} step_t;

	logic clk;
	logic reset;
	logic alloc_valid;
	logic alloc_ready;
	rob_tag_t alloc_tag;
	data_t alloc_data;
	logic alloc_data_valid;
	logic agu_valid;
	rob_tag_t agu_tag;
	addr_t agu_addr;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	data_t cdb_data;
	logic commit_valid;
	rob_tag_t commit_tag;
	logic load_valid;
	logic load_ready;
	addr_t load_addr;
	logic load_resp_valid;
	data_t load_data;
	logic load_forwarded;
	logic stq_empty;

	// model of every store in program order
	rob_tag_t m_tag [MAX_ST];
	addr_t m_addr [MAX_ST];
	data_t m_data [MAX_ST];
	logic m_av [MAX_ST];
	logic m_dv [MAX_ST];
	logic m_cm [MAX_ST];
	int n_st;
	// oldest store not yet committed
	int next_commit;

	step_t steps [$];
	logic [31:0] lfsr;
	rob_tag_t tag_ctr;
	int limit_cycles;

	// port names match one to one
	lsu_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic addr_t rand_addr();
		logic [31:0] w;
		logic [31:0] b;
		w = take_bits(2);
		b = take_bits(2);
		// four words at 0x200, byte offset must not matter
		return 32'h0000_0200 | (w << 2) | b;
	endfunction

	// youngest store with that tag
	function automatic int find_tag(input rob_tag_t tag);
		for (int i = n_st - 1; i >= 0; i--) begin
			if (m_tag[i] == tag) begin
				return i;
			end
		end
		return -1;
	endfunction

	// youngest store with a known matching word address decides the load
	// committed ones may or may not have drained, so the flag is free there
	function automatic int predict_load(input addr_t a, output data_t d);
		int hit;
		hit = -1;
		d = '0;
		for (int i = 0; i < n_st; i++) begin
			if (m_av[i] && m_addr[i][XLEN-1:2] == a[XLEN-1:2]) begin
				hit = i;
			end
		end
		if (hit < 0) begin
			return LK_MEM;
		end
		d = m_data[hit];
		if (!m_dv[hit]) begin
			return LK_STALL;
		end
		return m_cm[hit] ? LK_ANY : LK_FWD;
	endfunction

	task automatic send_alloc(input rob_tag_t tag, input data_t data, input logic dv);
		@(negedge clk);
		alloc_valid = 1'b1;
		alloc_tag = tag;
		alloc_data = data;
		alloc_data_valid = dv;
		#1;
		// full queue holds the request until the head drains
		while (!alloc_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		alloc_valid = 1'b0;
		m_tag[n_st] = tag;
		m_data[n_st] = data;
		m_dv[n_st] = dv;
		m_av[n_st] = 1'b0;
		m_cm[n_st] = 1'b0;
		n_st++;
	endtask

	task automatic send_agu(input int i, input addr_t a);
		@(negedge clk);
		agu_valid = 1'b1;
		agu_tag = m_tag[i];
		agu_addr = a;
		@(negedge clk);
		agu_valid = 1'b0;
		m_av[i] = 1'b1;
		m_addr[i] = a;
	endtask

	task automatic send_cdb(input int i, input data_t d);
		@(negedge clk);
		cdb_valid = 1'b1;
		cdb_tag = m_tag[i];
		cdb_data = d;
		@(negedge clk);
		cdb_valid = 1'b0;
		m_dv[i] = 1'b1;
		m_data[i] = d;
	endtask

	// commits are in program order
	task automatic send_commit(input int i);
		@(negedge clk);
		commit_valid = 1'b1;
		commit_tag = m_tag[i];
		@(negedge clk);
		commit_valid = 1'b0;
		m_cm[i] = 1'b1;
		next_commit = i + 1;
	endtask

	task automatic check_load(input addr_t a, input data_t exp_data, input logic check_flag,
		input logic exp_flag);
		@(negedge clk);
		load_valid = 1'b1;
		load_addr = a;
		#1;
		while (!load_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		load_valid = 1'b0;
		// response is due exactly one cycle after the accept
		assert (load_resp_valid) else begin
			abort_run("no load response in the cycle after the load was accepted");
		end
		assert (load_data == exp_data) else begin
			abort_run($sformatf("Error: load_data 0x%h expected 0x%h (address 0x%h)",
				load_data, exp_data, a));
		end
		if (check_flag) begin
			assert (load_forwarded == exp_flag) else begin
				abort_run($sformatf("Error: load_forwarded 0x%h expected 0x%h (address 0x%h)",
					load_forwarded, exp_flag, a));
			end
		end
	endtask

	// present a load that must be held off, then withdraw it
	task automatic check_stall(input addr_t a, input int cycles);
		@(negedge clk);
		load_valid = 1'b1;
		load_addr = a;
		for (int k = 0; k < cycles; k++) begin
			#1;
			assert (!load_ready) else begin
				abort_run($sformatf("Error: load_ready 0x%h expected 0x0 (address 0x%h)",
					load_ready, a));
			end
			@(negedge clk);
		end
		load_valid = 1'b0;
	endtask

	task automatic check_alloc_ready(input logic exp);
		@(negedge clk);
		#1;
		assert (alloc_ready == exp) else begin
			abort_run($sformatf("Error: alloc_ready 0x%h expected 0x%h", alloc_ready, exp));
		end
	endtask

	task automatic wait_empty();
		@(negedge clk);
		while (!stq_empty) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_step(input step_t s);
		case (s.op)
			OP_ALLOC: send_alloc(s.tag, s.data, s.dv);
			OP_AGU: send_agu(find_tag(s.tag), s.addr);
			OP_CDB: send_cdb(find_tag(s.tag), s.data);
			OP_COMMIT: send_commit(find_tag(s.tag));
			OP_LOAD: check_load(s.addr, s.exp_data, 1'b1, s.exp_flag);
			OP_STALL: check_stall(s.addr, 4);
			OP_EMPTY: wait_empty();
			OP_READY: check_alloc_ready(s.exp_flag);
		endcase
	endtask

	function automatic step_t mk(input op_t op, input int tag, input addr_t addr,
		input data_t data, input logic dv, input data_t exp_data, input logic exp_flag);
		step_t s;
		s.op = op;
		s.tag = rob_tag_t'(tag);
		s.addr = addr;
		s.data = data;
		s.dv = dv;
		s.exp_data = exp_data;
		s.exp_flag = exp_flag;
		return s;
	endfunction

	task automatic build_table();
		// eight stores fill the queue, tag 2 has no data yet
		steps.push_back(mk(OP_ALLOC, 1, 0, 32'h1111_0001, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 2, 0, 32'h0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 3, 0, 32'h3333_0003, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 4, 0, 32'h4444_0004, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 5, 0, 32'h5555_0005, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 6, 0, 32'h6666_0006, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 7, 0, 32'h7777_0007, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_ALLOC, 8, 0, 32'h8888_0008, 1'b1, 0, 1'b0));
		steps.push_back(mk(OP_READY, 0, 0, 0, 1'b0, 0, 1'b0));
		// two stores to 0x100, younger one forwards
		steps.push_back(mk(OP_AGU, 1, 32'h100, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 3, 32'h100, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h100, 0, 1'b0, 32'h3333_0003, 1'b1));
		steps.push_back(mk(OP_AGU, 4, 32'h104, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 5, 32'h108, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 6, 32'h104, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 7, 32'h10c, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 8, 32'h110, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h106, 0, 1'b0, 32'h6666_0006, 1'b1));
		steps.push_back(mk(OP_LOAD, 0, 32'h180, 0, 1'b0, 32'h0, 1'b0));
		// older tag 2 without data is shadowed by tag 5
		steps.push_back(mk(OP_AGU, 2, 32'h108, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h108, 0, 1'b0, 32'h5555_0005, 1'b1));
		steps.push_back(mk(OP_CDB, 2, 0, 32'h2222_0002, 1'b0, 0, 1'b0));
		// complete but uncommitted, still full
		steps.push_back(mk(OP_READY, 0, 0, 0, 1'b0, 0, 1'b0));
		for (int t = 1; t <= 8; t++) begin
			steps.push_back(mk(OP_COMMIT, t, 0, 0, 1'b0, 0, 1'b0));
		end
		steps.push_back(mk(OP_EMPTY, 0, 0, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_READY, 0, 0, 0, 1'b0, 0, 1'b1));
		// drained values, last store per word wins
		steps.push_back(mk(OP_LOAD, 0, 32'h100, 0, 1'b0, 32'h3333_0003, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h104, 0, 1'b0, 32'h6666_0006, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h108, 0, 1'b0, 32'h5555_0005, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h10c, 0, 1'b0, 32'h7777_0007, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h110, 0, 1'b0, 32'h8888_0008, 1'b0));
		// known address without data holds the load off until the cdb
		steps.push_back(mk(OP_ALLOC, 9, 0, 32'h0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_AGU, 9, 32'h120, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_STALL, 0, 32'h120, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_CDB, 9, 0, 32'h9999_0009, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h120, 0, 1'b0, 32'h9999_0009, 1'b1));
		steps.push_back(mk(OP_COMMIT, 9, 0, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_EMPTY, 0, 0, 0, 1'b0, 0, 1'b0));
		steps.push_back(mk(OP_LOAD, 0, 32'h120, 0, 1'b0, 32'h9999_0009, 1'b0));
	endtask

	// lowest open store from a random start among the uncommitted ones
	function automatic int pick_open(input logic need_addr);
		int cnt;
		int start;
		int i;
		cnt = n_st - next_commit;
		if (cnt == 0) begin
			return -1;
		end
		start = int'(take_bits(3));
		for (int k = 0; k < cnt; k++) begin
			i = next_commit + (start + k) % cnt;
			if (need_addr ? !m_av[i] : !m_dv[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic random_load(input addr_t a);
		data_t d;
		int kind;
		kind = predict_load(a, d);
		if (kind == LK_STALL) begin
			check_stall(a, 1);
		end else begin
			check_load(a, d, kind != LK_ANY, kind == LK_FWD);
		end
	endtask

	task automatic run_random(input int count);
		int sel;
		int i;
		data_t d;
		logic dv;
		for (int s = 0; s < count; s++) begin
			sel = int'(take_bits(3));
			case (sel)
				0, 1: begin
					// uncommitted stores alone must never fill the queue
					if (n_st - next_commit < STQ_SIZE) begin
						d = take_bits(32);
						dv = (take_bits(1) != 32'd0);
						send_alloc(tag_ctr, d, dv);
						tag_ctr = tag_ctr + rob_tag_t'(1);
					end
				end
				2: begin
					i = pick_open(1'b1);
					if (i >= 0) begin
						send_agu(i, rand_addr());
					end
				end
				3: begin
					i = pick_open(1'b0);
					if (i >= 0) begin
						send_cdb(i, take_bits(32));
					end
				end
				4, 5: begin
					// rob retires in order and only finished stores
					if (next_commit < n_st && m_av[next_commit] && m_dv[next_commit]) begin
						send_commit(next_commit);
					end
				end
				default: random_load(rand_addr());
			endcase
		end
	endtask

	task automatic finish_stores();
		addr_t a;
		data_t d;
		for (int i = next_commit; i < n_st; i++) begin
			if (!m_av[i]) begin
				send_agu(i, rand_addr());
			end
			if (!m_dv[i]) begin
				send_cdb(i, take_bits(32));
			end
		end
		while (next_commit < n_st) begin
			send_commit(next_commit);
		end
		wait_empty();
		// every random word holds its last store, nothing forwarded
		for (int w = 0; w < 4; w++) begin
			a = 32'h0000_0200 + addr_t'(w * 4);
			void'(predict_load(a, d));
			check_load(a, d, 1'b1, 1'b0);
		end
	endtask

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run($sformatf("run timed out after %0d cycles", limit_cycles));
	end

	initial begin
		reset = 1'b0;
		alloc_valid = 1'b0;
		alloc_tag = '0;
		alloc_data = '0;
		alloc_data_valid = 1'b0;
		agu_valid = 1'b0;
		agu_tag = '0;
		agu_addr = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit_valid = 1'b0;
		commit_tag = '0;
		load_valid = 1'b0;
		load_addr = '0;
		lfsr = LFSR_SEED;
		n_st = 0;
		next_commit = 0;
		tag_ctr = rob_tag_t'(16);
		build_table();
		// reset plus memory sweep, then a budget per step
		limit_cycles = (steps.size() + RAND_STEPS + 40) * STEP_CYCLES + 16 + MEM_WORDS;
		repeat (16) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		#1;
		assert (alloc_ready && stq_empty && !load_resp_valid) else begin
			abort_run($sformatf("Error: alloc_ready 0x%h stq_empty 0x%h load_resp_valid 0x%h",
				alloc_ready, stq_empty, load_resp_valid));
		end
		assert (!dut.u_drain.wr_valid && !dut.u_drain.store_succeeded) else begin
			abort_run($sformatf("Error: wr_valid 0x%h store_succeeded 0x%h after reset",
				dut.u_drain.wr_valid, dut.u_drain.store_succeeded));
		end
		// memory sweep still running
		while (!load_ready) begin
			@(negedge clk);
			#1;
		end
		foreach (steps[k]) begin
			apply_step(steps[k]);
		end
		run_random(RAND_STEPS);
		finish_stores();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
design/lsu_pkg.sv
design/store_queue.sv
design/store_drain_ctrl.sv
design/store_forward.sv
design/data_mem.sv
design/lsu_top.sv
verif/tb_lsu.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module tb_lsu
./obj_dir/Vtb_lsu > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
grep -q "STATUS: PASS" sim.log
